/* Makefile */
# Verilator build and run for the CNN accelerator testbench

VERILATOR ?= verilator
TOP       ?= hwcnn_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
verilog/hwcnn_pkg.sv
verilog/top_control.sv
verilog/ddr_load_control.sv
verilog/weight_bias_buffer.sv
verilog/feature_buffer.sv
verilog/line_window_control.sv
verilog/pe_core.sv
verilog/hwcnn_top.sv
verification/hwcnn_assertions.sv
verification/hwcnn_tb.sv

/* verification/hwcnn_assertions.sv */
module hwcnn_assertions (
	input  logic clk,
	input  logic rst_n,
	input  logic inst_empty,
	input  logic inst_req,
	input  logic ddr_fifo_empty,
	input  logic ddr_fifo_req,
	input  logic load_busy,
	input  logic result_valid
);

	int fail_count = 0;   // Failed assertion attempts

	// Stream pop needs a word present
	ddr_pop_only_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
		ddr_fifo_req |-> !ddr_fifo_empty)
		else begin
			fail_count++;
			$error("ddr_fifo_req raised while ddr_fifo_empty is high");
		end

	inst_pop_only_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
		inst_req |-> !inst_empty)
		else begin
			fail_count++;
			$error("inst_req raised while inst_empty is high");
		end

	// Loads and convolutions never overlap
	no_result_during_load: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> !load_busy)
		else begin
			fail_count++;
			$error("result_valid high while a load is busy");
		end

endmodule

bind hwcnn_top hwcnn_assertions protocol_checks (
	.clk(clk),
	.rst_n(rst_n),
	.inst_empty(inst_empty),
	.inst_req(inst_req),
	.ddr_fifo_empty(ddr_fifo_empty),
	.ddr_fifo_req(ddr_fifo_req),
	.load_busy(load_busy),
	.result_valid(result_valid)
);

/* verification/hwcnn_stim.txt */
# M <ddr word addr> <word>  I <opcode> <ddr addr> <len> <buf addr> <pool>  (hex)
# E <lane0> <lane1> <lane2> <lane3>  (signed decimal, one line per result strobe)
# Weights set 1, tap k in word k, byte l is lane l
M 0010 0200FF01
M 0011 FF030002
M 0012 FE000101
# Biases 5 -3 0 10
M 0020 0A00FD05
# Line 3 -2 7 1 0 -5 4 6 -1 2 8 -3
M 0030 0107FE03
M 0031 0604FB00
M 0032 FD0802FF
# Weights set 2
M 0040 03FE0100
M 0041 00000101
M 0042 FF020100
# Program A
I 0 0010 03 0 0
I 1 0020 01 0 0
I 2 0030 03 2 0
I 3 0000 0c 2 0
E 11 1 -6 4
E 18 0 21 -3
E 14 -10 3 23
E 1 -9 0 22
E -1 1 -15 7
E 14 8 12 -16
E 20 -8 18 14
E 11 -7 -3 19
E 16 6 6 -10
E 20 -8 24 12
# Program B, pooled over 11 samples then reload and run from word 3
I 3 0000 0b 2 1
I 0 0040 03 0 0
I 3 0000 08 3 0
E 18 1 21 4
E 14 -9 3 23
E 14 8 12 7
E 20 -7 18 19
E 0 -4 8 6
E 9 2 22 -11
E 11 6 -10 23
E 4 4 -8 26
E 7 6 18 -1
E 13 4 -10 19

/* verification/hwcnn_tb.sv */
module hwcnn_tb;
	import hwcnn_pkg::*;

	localparam string STIM_FILE    = "verification/hwcnn_stim.txt";
	localparam int    IDLE_CYCLES  = 20;
	localparam int    DONE_TIMEOUT = 2000;
	localparam int    DRAIN_CYCLES = 40;

	logic                  clk;
	logic                  rst_n;
	inst_t                 instruct;
	logic                  inst_empty;
	logic                  inst_req;
	logic                  ddr_conf;
	ddr_cmd_t              ddr_cmd;
	logic                  ddr_fifo_empty;
	logic                  ddr_fifo_req;
	logic [DDR_DATA_W-1:0] ddr_fifo_data;
	logic                  result_valid;
	result_t               result;

	integer                seed;
	logic                  inst_release;          // Queue model may present entries
	int                    result_count;
	logic [DDR_DATA_W-1:0] ddr_mem [2**DDR_ADDR_W];
	inst_t                 inst_fifo [$];
	logic [DDR_DATA_W-1:0] ddr_stream [$];
	result_t               expect_fifo [$];
	result_t               want;

	hwcnn_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.inst_req(inst_req),
		.ddr_conf(ddr_conf),
		.ddr_cmd(ddr_cmd),
		.ddr_fifo_empty(ddr_fifo_empty),
		.ddr_fifo_req(ddr_fifo_req),
		.ddr_fifo_data(ddr_fifo_data),
		.result_valid(result_valid),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////
	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			stop_with_error($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////////////////////////
	task automatic load_stimulus();
		int          fd;
		int          code;
		int          addr;
		int          l;
		logic [7:0]  tag;
		string       rest;
		logic [31:0] f_addr;
		logic [31:0] f_word;
		logic [31:0] f_op;
		logic [31:0] f_len;
		logic [31:0] f_buf;
		logic [31:0] f_pool;
		int          lane_val [X_PE];
		inst_t       inst;
		result_t     res;

		for (addr = 0; addr < 2**DDR_ADDR_W; addr++)
			ddr_mem[addr] = {addr[15:0], ~addr[15:0]};   // Unloaded words
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stop_with_error("cannot open the stimulus file");
		end else begin
			code = $fscanf(fd, " %c", tag);
			while (code == 1) begin
				case (tag)
					"#": code = $fgets(rest, fd);
					"M": begin
						code = $fscanf(fd, "%h %h", f_addr, f_word);
						ddr_mem[f_addr[DDR_ADDR_W-1:0]] = f_word;
					end
					"I": begin
						code = $fscanf(fd, "%h %h %h %h %h", f_op, f_addr, f_len, f_buf, f_pool);
						inst.opcode   = opcode_t'(f_op[1:0]);
						inst.ddr_addr = f_addr[DDR_ADDR_W-1:0];
						inst.len      = f_len[LEN_W-1:0];
						inst.buf_addr = f_buf[FB_ADDR_W-1:0];
						inst.pool     = f_pool[0];
						inst_fifo.push_back(inst);
					end
					"E": begin
						code = $fscanf(fd, "%d %d %d %d", lane_val[0], lane_val[1],
							lane_val[2], lane_val[3]);
						for (l = 0; l < X_PE; l++)
							res.lane[l] = ACC_W'(lane_val[l]);
						expect_fifo.push_back(res);
					end
					default: stop_with_error("unknown line tag in the stimulus file");
				endcase
				code = $fscanf(fd, " %c", tag);
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Instruction queue and DDR stream models
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin : bus_models
		int n;

		if (inst_req) begin
			if (inst_empty || inst_fifo.size() == 0)
				stop_with_error("instruction queue popped while empty");
			else
				void'(inst_fifo.pop_front());
		end
		// Random gaps in the queue
		if (inst_release && inst_fifo.size() != 0 && ($random(seed) & 3) != 0) begin
			instruct   <= inst_fifo[0];
			inst_empty <= 1'b0;
		end else begin
			inst_empty <= 1'b1;
		end

		if (ddr_fifo_req) begin
			if (ddr_fifo_empty || ddr_stream.size() == 0)
				stop_with_error("DDR stream popped while empty");
			else
				void'(ddr_stream.pop_front());
		end
		if (ddr_conf) begin
			for (n = 0; n < int'(ddr_cmd.len); n++)
				ddr_stream.push_back(ddr_mem[ddr_cmd.addr + DDR_ADDR_W'(n)]);
		end
		if (ddr_stream.size() != 0 && ($random(seed) & 3) != 0) begin   // Random stalls
			ddr_fifo_data  <= ddr_stream[0];
			ddr_fifo_empty <= 1'b0;
		end else begin
			ddr_fifo_empty <= 1'b1;
		end
	end

	// Results in file order
	always @(posedge clk) begin : result_monitor
		int l;

		if (rst_n && result_valid) begin
			if (expect_fifo.size() == 0) begin
				stop_with_error("result strobed with no expected result left");
			end else begin
				want = expect_fifo.pop_front();
				for (l = 0; l < X_PE; l++)
					check_value($sformatf("result %0d lane %0d", result_count, l),
						int'($signed(want.lane[l])), int'($signed(result.lane[l])));
				result_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////
	task automatic check_quiet_start();
		int c;

		for (c = 0; c < IDLE_CYCLES; c++) begin
			@(posedge clk);
			check_value("idle inst_req", 0, int'(inst_req));
			check_value("idle ddr_conf", 0, int'(ddr_conf));
			check_value("idle ddr_fifo_req", 0, int'(ddr_fifo_req));
			check_value("idle result_valid", 0, int'(result_valid));
		end
	endtask

	task automatic wait_for_programs();
		int cycles;
		int quiet;

		cycles = 0;
		while (inst_fifo.size() != 0 && cycles < DONE_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (inst_fifo.size() != 0)
			stop_with_error("timeout while waiting for the instructions to be fetched");
		// Last instruction is done once strobes and pops stop
		quiet = 0;
		while (quiet < DRAIN_CYCLES && cycles < DONE_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			if (result_valid || ddr_fifo_req)
				quiet = 0;
			else
				quiet++;
		end
		if (quiet < DRAIN_CYCLES)
			stop_with_error("timeout while waiting for the last instruction to finish");
	endtask

	initial begin
		seed           = 32'h5e17a405;
		result_count   = 0;
		rst_n          = 1'b0;
		inst_release   = 1'b0;
		instruct       = '0;
		inst_empty     = 1'b1;
		ddr_fifo_empty = 1'b1;
		ddr_fifo_data  = '0;
		load_stimulus();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		check_quiet_start();
		inst_release <= 1'b1;
		wait_for_programs();
		check_value("expected results left", 0, expect_fifo.size());
		if (uut.protocol_checks.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

/* verilog/ddr_load_control.sv */
module ddr_load_control (
	input  logic                              clk,
	input  logic                              rst_n,

	input  logic                              load_conf,
	input  hwcnn_pkg::load_cmd_t              load_cmd,
	output logic                              load_busy,

	output logic                              ddr_conf,
	output hwcnn_pkg::ddr_cmd_t               ddr_cmd,
	input  logic                              ddr_fifo_empty,
	output logic                              ddr_fifo_req,
	input  logic [hwcnn_pkg::DDR_DATA_W-1:0]  ddr_fifo_data,

	output hwcnn_pkg::buf_wr_t                buf_wr
);
	import hwcnn_pkg::*;

	logic [LEN_W-1:0]     remain;    // Words still to pop
	logic [FB_ADDR_W-1:0] wr_addr;
	load_dest_t           dest_q;
	logic                 pop;

	assign pop          = load_busy && (remain != '0) && !ddr_fifo_empty;
	assign ddr_fifo_req = pop;

	// Word goes to its store in the pop cycle
	assign buf_wr = '{dest: dest_q, en: pop, addr: wr_addr, data: ddr_fifo_data};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_busy <= 1'b0;
			ddr_conf  <= 1'b0;
			remain    <= '0;
		end else begin
			ddr_conf <= load_conf;   // DDR read one cycle after the command
			if (load_conf) begin
				load_busy <= 1'b1;
				remain    <= load_cmd.len;
			end else if (load_busy) begin
				if (pop)
					remain <= remain - 1'b1;
				if (remain == '0 || (pop && remain == LEN_W'(1)))
					load_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_conf) begin
			dest_q  <= load_cmd.dest;
			wr_addr <= load_cmd.buf_addr;
			ddr_cmd <= '{addr: load_cmd.ddr_addr, len: load_cmd.len};
		end else if (pop) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

endmodule

/* verilog/feature_buffer.sv */
module feature_buffer (
	input  logic                                 clk,
	input  hwcnn_pkg::buf_wr_t                   buf_wr,
	input  logic [hwcnn_pkg::SAMPLE_ADDR_W-1:0]  rd_addr,   // Sample index
	output logic [hwcnn_pkg::SAMPLE_W-1:0]       rd_data
);
	import hwcnn_pkg::*;

	logic [DDR_DATA_W-1:0] mem [2**FB_ADDR_W];
	logic [FB_ADDR_W-1:0]  rd_word;
	logic [1:0]            rd_byte;

	assign rd_word = rd_addr[SAMPLE_ADDR_W-1:2];
	assign rd_byte = rd_addr[1:0];

	always_ff @(posedge clk) begin
		if (buf_wr.en && buf_wr.dest == DEST_DATA)
			mem[buf_wr.addr] <= buf_wr.data;
	end

	// Registered read, lowest byte is the first sample of the word
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_word][rd_byte*SAMPLE_W +: SAMPLE_W];
	end

endmodule

/* verilog/hwcnn_pkg.sv */
package hwcnn_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int X_PE       = 4;    // Output channel lanes
	localparam int SAMPLE_W   = 8;
	localparam int ACC_W      = 20;
	localparam int DDR_DATA_W = 32;   // Four samples per word
	localparam int DDR_ADDR_W = 16;
	localparam int LEN_W      = 8;
	localparam int FB_ADDR_W  = 4;    // 16 words in the line buffer
	localparam int TAPS       = 3;
	localparam int SAMPLE_ADDR_W = FB_ADDR_W + 2;

	typedef enum logic [1:0] {
		OP_LOAD_WEIGHT = 2'd0,
		OP_LOAD_BIAS   = 2'd1,
		OP_LOAD_DATA   = 2'd2,
		OP_CONV        = 2'd3
	} opcode_t;

	typedef enum logic [1:0] {
		DEST_WEIGHT = 2'd0,
		DEST_BIAS   = 2'd1,
		DEST_DATA   = 2'd2
	} load_dest_t;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////
	typedef struct packed {
		opcode_t                 opcode;
		logic [DDR_ADDR_W-1:0]   ddr_addr;
		logic [LEN_W-1:0]        len;       // Words for loads, samples for conv
		logic [FB_ADDR_W-1:0]    buf_addr;
		logic                    pool;
	} inst_t;

	typedef struct packed {
		logic [DDR_ADDR_W-1:0]   addr;
		logic [LEN_W-1:0]        len;
	} ddr_cmd_t;

	typedef struct packed {
		load_dest_t              dest;
		logic [DDR_ADDR_W-1:0]   ddr_addr;
		logic [LEN_W-1:0]        len;
		logic [FB_ADDR_W-1:0]    buf_addr;
	} load_cmd_t;

	typedef struct packed {
		load_dest_t              dest;
		logic                    en;
		logic [FB_ADDR_W-1:0]    addr;
		logic [DDR_DATA_W-1:0]   data;
	} buf_wr_t;

	typedef struct packed {
		logic [FB_ADDR_W-1:0]    start;
		logic [LEN_W-1:0]        len;
		logic                    pool;
	} conv_cmd_t;

	typedef struct packed {
		logic [TAPS-1:0][SAMPLE_W-1:0] sample;  // Index 0 is the oldest
		logic                          valid;
	} window_t;

	typedef struct packed {
		logic [X_PE-1:0][ACC_W-1:0] lane;
	} result_t;

endpackage

/* verilog/hwcnn_top.sv */
module hwcnn_top (
	input  logic                              clk,
	input  logic                              rst_n,

	input  hwcnn_pkg::inst_t                  instruct,
	input  logic                              inst_empty,
	output logic                              inst_req,

	output logic                              ddr_conf,
	output hwcnn_pkg::ddr_cmd_t               ddr_cmd,
	input  logic                              ddr_fifo_empty,
	output logic                              ddr_fifo_req,
	input  logic [hwcnn_pkg::DDR_DATA_W-1:0]  ddr_fifo_data,

	output logic                              result_valid,
	output hwcnn_pkg::result_t                result
);
	import hwcnn_pkg::*;

	logic                          load_conf;
	load_cmd_t                     load_cmd;
	logic                          load_busy;
	logic                          conv_conf;
	conv_cmd_t                     conv_cmd;
	logic                          window_busy;
	logic                          pe_busy;
	buf_wr_t                       buf_wr;
	logic [SAMPLE_ADDR_W-1:0]      rd_addr;
	logic [SAMPLE_W-1:0]           rd_data;
	window_t                       window;
	logic [X_PE*TAPS*SAMPLE_W-1:0] taps;
	logic [X_PE*SAMPLE_W-1:0]      biases;

	top_control tctrl (
		.clk(clk),
		.rst_n(rst_n),
		.instruct(instruct),
		.inst_empty(inst_empty),
		.inst_req(inst_req),
		.load_conf(load_conf),
		.load_cmd(load_cmd),
		.load_busy(load_busy),
		.conv_conf(conv_conf),
		.conv_cmd(conv_cmd),
		.window_busy(window_busy),
		.pe_busy(pe_busy)
	);

	// Single loader for all three stores
	ddr_load_control dlc (
		.clk(clk),
		.rst_n(rst_n),
		.load_conf(load_conf),
		.load_cmd(load_cmd),
		.load_busy(load_busy),
		.ddr_conf(ddr_conf),
		.ddr_cmd(ddr_cmd),
		.ddr_fifo_empty(ddr_fifo_empty),
		.ddr_fifo_req(ddr_fifo_req),
		.ddr_fifo_data(ddr_fifo_data),
		.buf_wr(buf_wr)
	);

	weight_bias_buffer wbb (
		.clk(clk),
		.rst_n(rst_n),
		.buf_wr(buf_wr),
		.taps(taps),
		.biases(biases)
	);

	feature_buffer fbuf (
		.clk(clk),
		.buf_wr(buf_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	line_window_control lwc (
		.clk(clk),
		.rst_n(rst_n),
		.conv_conf(conv_conf),
		.conv_cmd(conv_cmd),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.window(window),
		.window_busy(window_busy)
	);

	pe_core pec (
		.clk(clk),
		.rst_n(rst_n),
		.conv_conf(conv_conf),
		.conv_cmd(conv_cmd),
		.window(window),
		.taps(taps),
		.biases(biases),
		.result_valid(result_valid),
		.result(result),
		.pe_busy(pe_busy)
	);

endmodule

/* verilog/line_window_control.sv */
module line_window_control (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 conv_conf,
	input  hwcnn_pkg::conv_cmd_t                 conv_cmd,
	output logic [hwcnn_pkg::SAMPLE_ADDR_W-1:0]  rd_addr,
	input  logic [hwcnn_pkg::SAMPLE_W-1:0]       rd_data,
	output hwcnn_pkg::window_t                   window,
	output logic                                 window_busy
);
	import hwcnn_pkg::*;

	logic                          reading;
	logic [LEN_W-1:0]              remain;
	logic                          rd_valid;   // rd_data holds a sample this cycle
	logic [1:0]                    fill;       // Samples already in the window
	logic [TAPS-1:0][SAMPLE_W-1:0] win_q;
	logic                          win_valid;

	////////////////////////////////////////////////////////////
	// Address sequencer and window fill
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reading   <= 1'b0;
			remain    <= '0;
			rd_addr   <= '0;
			rd_valid  <= 1'b0;
			fill      <= '0;
			win_valid <= 1'b0;
		end else begin
			rd_valid  <= reading;
			win_valid <= rd_valid && (fill == 2'(TAPS-1));
			if (conv_conf) begin
				reading <= (conv_cmd.len != '0);
				remain  <= conv_cmd.len;
				rd_addr <= {conv_cmd.start, 2'b00};
				fill    <= '0;
			end else begin
				if (reading) begin
					rd_addr <= rd_addr + 1'b1;
					remain  <= remain - 1'b1;
					if (remain == LEN_W'(1))
						reading <= 1'b0;
				end
				if (rd_valid && fill != 2'(TAPS-1))
					fill <= fill + 1'b1;
			end
		end
	end

	// Newest sample enters at the top
	always_ff @(posedge clk) begin
		if (rd_valid)
			win_q <= {rd_data, win_q[TAPS-1:1]};
	end

	assign window      = '{sample: win_q, valid: win_valid};
	assign window_busy = reading || rd_valid || win_valid;

endmodule

/* verilog/pe_core.sv */
module pe_core (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	input  logic                                                       conv_conf,
	input  hwcnn_pkg::conv_cmd_t                                       conv_cmd,
	input  hwcnn_pkg::window_t                                         window,
	input  logic [hwcnn_pkg::X_PE*hwcnn_pkg::TAPS*hwcnn_pkg::SAMPLE_W-1:0] taps,
	input  logic [hwcnn_pkg::X_PE*hwcnn_pkg::SAMPLE_W-1:0]               biases,
	output logic                                                       result_valid,
	output hwcnn_pkg::result_t                                         result,
	output logic                                                       pe_busy
);
	import hwcnn_pkg::*;

	logic signed [ACC_W-1:0] sum_d  [X_PE];
	logic signed [ACC_W-1:0] acc_q  [X_PE];
	logic signed [ACC_W-1:0] held_q [X_PE];   // First value of a pool pair
	logic                    acc_valid;
	logic                    pool_q;
	logic                    phase_q;          // High on the second of a pair

	////////////////////////////////////////////////////////////
	// 3-tap MAC per lane
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < X_PE; l++) begin
			sum_d[l] = $signed(biases[l*SAMPLE_W +: SAMPLE_W]);
			for (int k = 0; k < TAPS; k++) begin
				sum_d[l] = sum_d[l] + $signed(window.sample[k])
					* $signed(taps[(l*TAPS + k)*SAMPLE_W +: SAMPLE_W]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
			pool_q    <= 1'b0;
			phase_q   <= 1'b0;
		end else begin
			acc_valid <= window.valid;
			if (conv_conf) begin
				pool_q  <= conv_cmd.pool;
				phase_q <= 1'b0;
			end else if (acc_valid && pool_q) begin
				phase_q <= !phase_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (window.valid)
			acc_q <= sum_d;
		if (acc_valid && !phase_q)
			held_q <= acc_q;
	end

	////////////////////////////////////////////////////////////
	// Output and pair max pool
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < X_PE; l++) begin
			if (pool_q && held_q[l] > acc_q[l])
				result.lane[l] = held_q[l];
			else
				result.lane[l] = acc_q[l];
		end
	end

	// Odd last value of a pooled line never strobes
	assign result_valid = acc_valid && (!pool_q || phase_q);
	assign pe_busy      = acc_valid;

endmodule

/* verilog/top_control.sv */
module top_control (
	input  logic                  clk,
	input  logic                  rst_n,

	input  hwcnn_pkg::inst_t      instruct,
	input  logic                  inst_empty,
	output logic                  inst_req,

	output logic                  load_conf,
	output hwcnn_pkg::load_cmd_t  load_cmd,
	input  logic                  load_busy,

	output logic                  conv_conf,
	output hwcnn_pkg::conv_cmd_t  conv_cmd,
	input  logic                  window_busy,
	input  logic                  pe_busy
);
	import hwcnn_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_LOAD_WAIT,
		ST_CONV_WAIT
	} state_t;

	state_t     state;
	inst_t      inst_q;
	load_dest_t dest;

	// Pop only from a non-empty queue
	assign inst_req = (state == ST_IDLE) && !inst_empty;

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!inst_empty)
						state <= ST_DECODE;
				end
				ST_DECODE: begin
					if (inst_q.opcode == OP_CONV)
						state <= ST_CONV_WAIT;
					else
						state <= ST_LOAD_WAIT;
				end
				ST_LOAD_WAIT: begin
					if (!load_busy)
						state <= ST_IDLE;
				end
				ST_CONV_WAIT: begin
					// Both the reader and the PE pipeline must drain
					if (!window_busy && !pe_busy)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_req)
			inst_q <= instruct;   // Latched in the pop cycle
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb begin
		case (inst_q.opcode)
			OP_LOAD_WEIGHT: dest = DEST_WEIGHT;
			OP_LOAD_BIAS:   dest = DEST_BIAS;
			default:        dest = DEST_DATA;
		endcase
	end

	assign load_conf = (state == ST_DECODE) && (inst_q.opcode != OP_CONV);
	assign conv_conf = (state == ST_DECODE) && (inst_q.opcode == OP_CONV);

	assign load_cmd = '{dest: dest, ddr_addr: inst_q.ddr_addr, len: inst_q.len,
		buf_addr: inst_q.buf_addr};
	assign conv_cmd = '{start: inst_q.buf_addr, len: inst_q.len, pool: inst_q.pool};

endmodule

/* verilog/weight_bias_buffer.sv */
module weight_bias_buffer (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	input  hwcnn_pkg::buf_wr_t                                         buf_wr,
	output logic [hwcnn_pkg::X_PE*hwcnn_pkg::TAPS*hwcnn_pkg::SAMPLE_W-1:0] taps,
	output logic [hwcnn_pkg::X_PE*hwcnn_pkg::SAMPLE_W-1:0]               biases
);
	import hwcnn_pkg::*;

	logic [DDR_DATA_W-1:0] weight_q [TAPS];   // Word k is tap k of every lane
	logic [DDR_DATA_W-1:0] bias_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < TAPS; k++)
				weight_q[k] <= '0;
			bias_q <= '0;
		end else if (buf_wr.en) begin
			for (int k = 0; k < TAPS; k++) begin
				if (buf_wr.dest == DEST_WEIGHT && buf_wr.addr == FB_ADDR_W'(k))
					weight_q[k] <= buf_wr.data;
			end
			if (buf_wr.dest == DEST_BIAS && buf_wr.addr == '0)
				bias_q <= buf_wr.data;
		end
	end

	// Byte l of a word belongs to lane l
	always_comb begin
		for (int l = 0; l < X_PE; l++) begin
			for (int k = 0; k < TAPS; k++)
				taps[(l*TAPS + k)*SAMPLE_W +: SAMPLE_W] = weight_q[k][l*SAMPLE_W +: SAMPLE_W];
		end
	end

	assign biases = bias_q;

endmodule
